/* logic/umode_pkg.sv */
// ------------------
// Shared types and constants of the user-mode checker
//   privilege, instruction class, cause and rule enums
//   mstatus and mcounteren field positions
//   system instruction encodings
// ------------------

package umode_pkg;

  // Privilege levels as seen on the retirement trace
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_R = 2'd2,
    PRIV_M = 2'd3
  } priv_mode_e;

  // Opcode classes that the rules care about
  typedef enum logic [2:0] {
    CLS_NONE   = 3'd0,
    CLS_MRET   = 3'd1,
    CLS_WFI    = 3'd2,
    CLS_URET   = 3'd3,
    CLS_CUSTOM = 3'd4,
    CLS_ECALL  = 3'd5,
    CLS_CSR    = 3'd6
  } insn_class_e;

  // Exception causes referenced by the rules
  typedef enum logic [5:0] {
    EXC_INSTR_FAULT     = 6'd1,
    EXC_ILLEGAL_INSN    = 6'd2,
    EXC_ECALL_UMODE     = 6'd8,
    EXC_INSTR_BUS_FAULT = 6'd24
  } exc_cause_e;

  // Rule index, also the bit position in the violation vectors
  typedef enum logic [3:0] {
    R0_MODE, R1_FIRST, R2_MPP, R3_EXT, R4_TRAP,
    R5_INTR, R6_ILLEGAL, R7_ECALL, R8_DEBUG, R9_MRET
  } rule_e;

  localparam int NUM_RULES = 10;

  // mstatus fields
  localparam int MPP_POS = 11;
  localparam int SPP_POS = 8;
  localparam int TW_POS  = 21;
  localparam int XS_POS  = 15;
  localparam int FS_POS  = 13;
  localparam int SD_POS  = 31;
  // mcounteren cycle enable
  localparam int CY_POS  = 0;

  // Exact system encodings
  localparam logic [31:0] MRET_INSN  = 32'h3020_0073;
  localparam logic [31:0] WFI_INSN   = 32'h1050_0073;
  localparam logic [31:0] URET_INSN  = 32'h0020_0073;
  localparam logic [31:0] ECALL_INSN = 32'h0000_0073;

  // Custom system space, funct6 plus funct3 plus opcode compared
  localparam logic [31:0] CUSTOM0_INSN = 32'h8C00_0073;
  localparam logic [31:0] CUSTOM1_INSN = 32'hCC00_0073;
  localparam logic [31:0] CUSTOM_MASK  = 32'hFC00_707F;

  localparam logic [6:0]  SYSTEM_OPCODE  = 7'b111_0011;
  localparam logic [11:0] CSR_CYCLE_ADDR = 12'hC00;

endpackage

/* logic/retire_if.sv */
// ------------------
// One decoded retirement
//   decode side drives, check side reads
// ------------------

`timescale 1ns/1ps

interface retire_if import umode_pkg::*; ();

  logic        valid;
  priv_mode_e  mode;
  insn_class_e insn_class;
  // Privilege bits [29:28] of the CSR address
  logic [1:0]  csr_priv;
  logic        csr_is_cycle;
  logic        exception;
  logic [5:0]  cause;
  logic        interrupt;
  logic        dbg_mode;
  logic [31:0] mstatus;
  // mcounteren.CY as read at retirement
  logic        cy_enable;

  modport decode (
    output valid, mode, insn_class, csr_priv, csr_is_cycle,
    output exception, cause, interrupt, dbg_mode, mstatus, cy_enable
  );

  modport check (
    input valid, mode, insn_class, csr_priv, csr_is_cycle,
    input exception, cause, interrupt, dbg_mode, mstatus, cy_enable
  );

endinterface

/* logic/insn_decode.sv */
// ------------------
// Retirement decoder
//   revoked-fetch detection
//   instruction class match
//   CSR address fields
// ------------------

`timescale 1ns/1ps

module insn_decode import umode_pkg::*; (
  input  logic        rvfi_valid,
  input  logic [1:0]  rvfi_mode,
  input  logic [31:0] rvfi_insn,
  input  logic        trap_exception,
  input  logic [5:0]  trap_cause,
  input  logic        intr_interrupt,
  input  logic        dbg_mode,
  input  logic [31:0] mstatus,
  input  logic [31:0] mcounteren,
  retire_if.decode    ret
);

  logic       revoked;
  logic       is_system;
  logic       is_csr;
  logic [2:0] funct3;

  // Fetch faulted, so the word never really executed
  assign revoked = trap_exception &&
                   ((trap_cause == EXC_INSTR_FAULT) || (trap_cause == EXC_INSTR_BUS_FAULT));

  assign funct3    = rvfi_insn[14:12];
  assign is_system = (rvfi_insn[6:0] == SYSTEM_OPCODE);
  // funct3 of 0 is priv ops, 4 is reserved
  assign is_csr    = is_system && (funct3 != 3'd0) && (funct3 != 3'd4);

  // Class match, revoked words stay in class none
  always_comb begin
    ret.insn_class = CLS_NONE;
    if (!revoked) begin
      if (rvfi_insn == MRET_INSN) begin
        ret.insn_class = CLS_MRET;
      end else if (rvfi_insn == WFI_INSN) begin
        ret.insn_class = CLS_WFI;
      end else if (rvfi_insn == URET_INSN) begin
        ret.insn_class = CLS_URET;
      end else if (rvfi_insn == ECALL_INSN) begin
        ret.insn_class = CLS_ECALL;
      end else if (((rvfi_insn & CUSTOM_MASK) == CUSTOM0_INSN) ||
                   ((rvfi_insn & CUSTOM_MASK) == CUSTOM1_INSN)) begin
        ret.insn_class = CLS_CUSTOM;
      end else if (is_csr) begin
        ret.insn_class = CLS_CSR;
      end
    end
  end

  // CSR address sits in [31:20]
  assign ret.csr_priv     = rvfi_insn[29:28];
  assign ret.csr_is_cycle = (rvfi_insn[31:20] == CSR_CYCLE_ADDR);

  // Pass-through of the remaining trace fields
  assign ret.valid     = rvfi_valid;
  assign ret.mode      = priv_mode_e'(rvfi_mode);
  assign ret.exception = trap_exception;
  assign ret.cause     = trap_cause;
  assign ret.interrupt = intr_interrupt;
  assign ret.dbg_mode  = dbg_mode;
  assign ret.mstatus   = mstatus;
  assign ret.cy_enable = mcounteren[CY_POS];

endmodule

/* logic/rule_check.sv */
// ------------------
// Rule evaluation
//   single-retirement rules
//   first, trap and mret history
//   registered violation vector
// ------------------

`timescale 1ns/1ps

module rule_check import umode_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  retire_if.check              ret,
  output logic                 viol_valid,
  output logic [NUM_RULES-1:0] viol_vec
);

  logic                 is_user;
  logic                 not_mach;
  logic                 trap_illegal;
  logic                 must_illegal;
  logic                 tw;
  priv_mode_e           mpp;
  logic [NUM_RULES-1:0] vec;

  // History across retirements
  logic       first_q;
  logic       prev_trap_q;
  logic       mret_pend_q;
  priv_mode_e mret_mpp_q;

  assign is_user      = (ret.mode == PRIV_U);
  assign not_mach     = (ret.mode != PRIV_M);
  assign trap_illegal = ret.exception && (ret.cause == EXC_ILLEGAL_INSN);
  assign tw           = ret.mstatus[TW_POS];
  assign mpp          = priv_mode_e'(ret.mstatus[MPP_POS +: 2]);

  // Cases that have to end in an illegal-instruction trap
  always_comb begin
    case (ret.insn_class)
      CLS_URET, CLS_CUSTOM: must_illegal = 1'b1;
      CLS_MRET:             must_illegal = is_user;
      CLS_WFI:              must_illegal = is_user && tw;
      CLS_CSR: begin
        // Higher CSR, or cycle counter not granted to U
        must_illegal = is_user &&
                       ((ret.csr_priv != PRIV_U) || (ret.csr_is_cycle && !ret.cy_enable));
      end
      default:              must_illegal = 1'b0;
    endcase
  end

  always_comb begin
    vec = '0;
    if (ret.valid) begin
      vec[R0_MODE]    = (ret.mode == PRIV_S) || (ret.mode == PRIV_R);
      vec[R1_FIRST]   = first_q && not_mach;
      vec[R2_MPP]     = (mpp != PRIV_U) && (mpp != PRIV_M);
      vec[R3_EXT]     = ret.mstatus[SPP_POS] || (|ret.mstatus[XS_POS +: 2]) ||
                        (|ret.mstatus[FS_POS +: 2]) || ret.mstatus[SD_POS];
      vec[R4_TRAP]    = prev_trap_q && not_mach;
      vec[R5_INTR]    = ret.interrupt && not_mach;
      // Missing illegal trap, or a wfi with TW clear that trapped anyway
      vec[R6_ILLEGAL] = (must_illegal && !trap_illegal) ||
                        ((ret.insn_class == CLS_WFI) && is_user && !tw && trap_illegal);
      vec[R7_ECALL]   = (ret.insn_class == CLS_ECALL) && is_user &&
                        !(ret.exception && (ret.cause == EXC_ECALL_UMODE));
      vec[R8_DEBUG]   = ret.dbg_mode && not_mach;
      // Interrupt entry and debug entry may override the return mode
      vec[R9_MRET]    = mret_pend_q && !ret.interrupt && !ret.dbg_mode &&
                        (ret.mode != mret_mpp_q);
    end
  end

  // History advances only on a real retirement
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      first_q     <= 1'b1;
      prev_trap_q <= 1'b0;
      mret_pend_q <= 1'b0;
    end else if (ret.valid) begin
      first_q     <= 1'b0;
      prev_trap_q <= ret.exception;
      mret_pend_q <= (ret.insn_class == CLS_MRET) && (ret.mode == PRIV_M) && !ret.dbg_mode;
    end
  end

  // Saved MPP, only meaningful while mret_pend_q is set
  always_ff @(posedge clk_i) begin
    if (ret.valid) begin
      mret_mpp_q <= mpp;
    end
  end

  // Output stage, one cycle after the retirement
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      viol_valid <= 1'b0;
      viol_vec   <= '0;
    end else begin
      viol_valid <= ret.valid;
      viol_vec   <= vec;
    end
  end

endmodule

/* logic/violation_log.sv */
// ------------------
// Violation log
//   sticky rule mask
//   saturating error counter
//   first violation record
// ------------------

`timescale 1ns/1ps

module violation_log import umode_pkg::*; #(
  parameter int CNT_W = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 viol_valid,
  input  logic [NUM_RULES-1:0] viol_vec,
  output logic [CNT_W-1:0]     err_count,
  output logic [NUM_RULES-1:0] sticky_mask,
  output rule_e                first_rule,
  output logic                 first_valid
);

  logic  any_viol;
  rule_e lowest;

  assign any_viol = viol_valid && (|viol_vec);

  // Priority pick, scanning down so the lowest set bit wins
  always_comb begin
    lowest = R0_MODE;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (viol_vec[i]) begin
        lowest = rule_e'(i[3:0]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_count   <= '0;
      sticky_mask <= '0;
      first_rule  <= R0_MODE;
      first_valid <= 1'b0;
    end else if (viol_valid) begin
      sticky_mask <= sticky_mask | viol_vec;
      // Counter holds at all ones
      if (any_viol && (err_count != {CNT_W{1'b1}})) begin
        err_count <= err_count + 1'b1;
      end
      // Kept until the next reset
      if (any_viol && !first_valid) begin
        first_rule  <= lowest;
        first_valid <= 1'b1;
      end
    end
  end

endmodule

/* logic/umode_checker_top.sv */
// ------------------
// User-mode privilege checker top
//   decoder, rule checker and log
// ------------------

`timescale 1ns/1ps

module umode_checker_top import umode_pkg::*; #(
  parameter int CNT_W = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Retirement trace
  input  logic                 rvfi_valid,
  input  logic [1:0]           rvfi_mode,
  input  logic [31:0]          rvfi_insn,
  input  logic                 trap_exception,
  input  logic [5:0]           trap_cause,
  input  logic                 intr_interrupt,
  input  logic                 dbg_mode,
  // CSR read values at retirement
  input  logic [31:0]          mstatus,
  input  logic [31:0]          mcounteren,
  // Results
  output logic                 viol_valid,
  output logic [NUM_RULES-1:0] viol_vec,
  output logic [CNT_W-1:0]     err_count,
  output logic [NUM_RULES-1:0] sticky_mask,
  output rule_e                first_rule,
  output logic                 first_valid
);

  retire_if ret ();

  insn_decode u_decode (
    .rvfi_valid     (rvfi_valid),
    .rvfi_mode      (rvfi_mode),
    .rvfi_insn      (rvfi_insn),
    .trap_exception (trap_exception),
    .trap_cause     (trap_cause),
    .intr_interrupt (intr_interrupt),
    .dbg_mode       (dbg_mode),
    .mstatus        (mstatus),
    .mcounteren     (mcounteren),
    .ret            (ret.decode)
  );

  rule_check u_check (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ret        (ret.check),
    .viol_valid (viol_valid),
    .viol_vec   (viol_vec)
  );

  violation_log #(
    .CNT_W (CNT_W)
  ) u_log (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .viol_valid  (viol_valid),
    .viol_vec    (viol_vec),
    .err_count   (err_count),
    .sticky_mask (sticky_mask),
    .first_rule  (first_rule),
    .first_valid (first_valid)
  );

endmodule

/* verification/umode_checker_monitor.sv */
// --------------------
// Checker of the testbench
//   vector compare one cycle after a retirement
//   log model and compare two cycles after
// --------------------

`timescale 1ns/1ps

module umode_checker_monitor import umode_pkg::*; #(
  parameter int CNT_W = 16
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 exp_valid,
  input logic [NUM_RULES-1:0] exp_vec,
  input logic                 viol_valid,
  input logic [NUM_RULES-1:0] viol_vec,
  input logic [CNT_W-1:0]     err_count,
  input logic [NUM_RULES-1:0] sticky_mask,
  input logic [3:0]           first_rule,
  input logic                 first_valid
);

  // Written by the testbench top, follows the pipeline
  string test_name = "idle";
  string name_d1 = "idle";
  string name_d2 = "idle";
  int    vec_errors = 0;
  int    log_errors = 0;

  logic                 exp_valid_d1;
  logic [NUM_RULES-1:0] exp_vec_d1;
  // Expected log state
  logic [CNT_W-1:0]     model_count;
  logic [NUM_RULES-1:0] model_mask;
  logic [3:0]           model_first;
  logic                 model_first_valid;

  // Index of the first set bit, searching upward from R0
  function automatic logic [3:0] lowest_rule(input logic [NUM_RULES-1:0] v);
    logic [3:0] r;
    logic       found;
    r = 4'd0;
    found = 1'b0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (v[i] && !found) begin
        r = 4'(i);
        found = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic check(input string name, input string field, input logic [31:0] exp,
      input logic [31:0] act, input bit log_stage);
    if (act !== exp) begin
      $display("FAILED %s %s expected %h actual %h", name, field, exp, act);
      if (log_stage) log_errors++;
      else vec_errors++;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      exp_valid_d1 = 1'b0;
      exp_vec_d1 = '0;
      model_count = '0;
      model_mask = '0;
      model_first = 4'd0;
      model_first_valid = 1'b0;
    end else begin
      // Log outputs reflect everything up to two cycles back
      check(name_d2, "err_count", 32'(model_count), 32'(err_count), 1'b1);
      check(name_d2, "sticky_mask", 32'(model_mask), 32'(sticky_mask), 1'b1);
      check(name_d2, "first_valid", 32'(model_first_valid), 32'(first_valid), 1'b1);
      if (model_first_valid) check(name_d2, "first_rule", 32'(model_first), 32'(first_rule), 1'b1);
      check(name_d1, "viol_valid", 32'(exp_valid_d1), 32'(viol_valid), 1'b0);
      if (exp_valid_d1) begin
        check(name_d1, "viol_vec", 32'(exp_vec_d1), 32'(viol_vec), 1'b0);
        model_mask = model_mask | exp_vec_d1;
        if (|exp_vec_d1) begin
          if (model_count != '1) model_count++;
          if (!model_first_valid) begin
            model_first = lowest_rule(exp_vec_d1);
            model_first_valid = 1'b1;
          end
        end
      end
      name_d2 = name_d1;
      name_d1 = test_name;
      exp_valid_d1 = exp_valid;
      exp_vec_d1 = exp_vec;
    end
  end

endmodule

/* verification/umode_checker_tb.sv */
// --------------------
// Testbench for the user-mode checker
//   clock, reset and LFSR stimulus
//   reference model of the ten rules
//   directed and random sequences
// --------------------

`timescale 1ns/1ps

module umode_checker_tb import umode_pkg::*; ();

  localparam logic [1:0]  U        = 2'd0;
  localparam logic [1:0]  M        = 2'd3;
  localparam logic [31:0] NOP      = 32'h0000_0013;
  localparam logic [31:0] MS_M     = 32'h0000_1800;
  // csrrs x1, mstatus and csrrs x1, cycle
  localparam logic [31:0] RD_MSTAT = 32'h3000_20F3;
  localparam logic [31:0] RD_CYCLE = 32'hC000_20F3;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        rvfi_valid, trap_exception, intr_interrupt, dbg_mode;
  logic [1:0]  rvfi_mode;
  logic [31:0] rvfi_insn, mstatus, mcounteren;
  logic [5:0]  trap_cause;
  logic        viol_valid, first_valid;
  logic [9:0]  viol_vec, sticky_mask;
  logic [15:0] err_count;
  logic [3:0]  first_rule;
  // Expected result of the retirement now on the inputs
  logic        exp_valid;
  logic [9:0]  exp_vec;
  // Reference history and LFSR state
  logic        first_s, trap_s, mret_s;
  logic [1:0]  mret_mpp_s;
  logic [31:0] lfsr = 32'he8c02d2a;
  int          timeouts = 0;

  always #20 clk_i = ~clk_i;

  umode_checker_top #(.CNT_W(16)) UUT (
    .clk_i(clk_i), .rst_ni(rst_ni), .rvfi_valid(rvfi_valid), .rvfi_mode(rvfi_mode),
    .rvfi_insn(rvfi_insn), .trap_exception(trap_exception), .trap_cause(trap_cause),
    .intr_interrupt(intr_interrupt), .dbg_mode(dbg_mode), .mstatus(mstatus),
    .mcounteren(mcounteren), .viol_valid(viol_valid), .viol_vec(viol_vec),
    .err_count(err_count), .sticky_mask(sticky_mask), .first_rule(first_rule),
    .first_valid(first_valid)
  );

  umode_checker_monitor #(.CNT_W(16)) u_mon (
    .clk_i(clk_i), .rst_ni(rst_ni), .exp_valid(exp_valid), .exp_vec(exp_vec),
    .viol_valid(viol_valid), .viol_vec(viol_vec), .err_count(err_count),
    .sticky_mask(sticky_mask), .first_rule(first_rule), .first_valid(first_valid)
  );

  // Galois LFSR, one step per bit, newest bit in the LSB
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h8020_0003;
      r = {r[30:0], lsb};
    end
    return r;
  endfunction

  // Fetch fault or fetch bus fault
  function automatic logic is_revoked(input logic exc, input logic [5:0] cause);
    return exc && ((cause == 6'd1) || (cause == 6'd24));
  endfunction

  // Expected violation vector of one valid retirement
  function automatic logic [9:0] ref_vec(input logic [1:0] m, input logic [31:0] insn,
      input logic exc, input logic [5:0] cause, input logic intr, input logic dbg,
      input logic [31:0] ms, input logic [31:0] mc);
    logic [9:0] v;
    logic       live, user, mach, ill, must, wfi, csr;
    logic [1:0] mpp;
    live = !is_revoked(exc, cause);
    user = (m == 2'd0);
    mach = (m == 2'd3);
    ill  = exc && (cause == 6'd2);
    mpp  = ms[12:11];
    wfi  = live && (insn == WFI_INSN);
    csr  = live && (insn[6:0] == 7'h73) && (insn[14:12] != 3'd0) && (insn[14:12] != 3'd4);
    must = live && ((insn == URET_INSN) || ((insn & CUSTOM_MASK) == CUSTOM0_INSN) ||
                    ((insn & CUSTOM_MASK) == CUSTOM1_INSN));
    // User-only cases: mret, wfi under TW, higher CSR, cycle without CY
    must = must || (user && live && (insn == MRET_INSN)) || (user && wfi && ms[21]) ||
           (user && csr && ((insn[29:28] != 2'd0) || ((insn[31:20] == 12'hC00) && !mc[0])));
    v[0] = (m == 2'd1) || (m == 2'd2);
    v[1] = first_s && !mach;
    v[2] = (mpp == 2'd1) || (mpp == 2'd2);
    v[3] = ms[8] || ms[16] || ms[15] || ms[14] || ms[13] || ms[31];
    v[4] = trap_s && !mach;
    v[5] = intr && !mach;
    v[6] = (must && !ill) || (wfi && user && !ms[21] && ill);
    v[7] = live && (insn == ECALL_INSN) && user && !(exc && (cause == 6'd8));
    v[8] = dbg && !mach;
    v[9] = mret_s && !intr && !dbg && (m != mret_mpp_s);
    return v;
  endfunction

  // Drive one cycle at the falling edge and advance the reference history
  task automatic retire(input logic v, input logic [1:0] m, input logic [31:0] insn,
      input logic exc, input logic [5:0] cause, input logic intr, input logic dbg,
      input logic [31:0] ms, input logic [31:0] mc);
    rvfi_valid = v;
    rvfi_mode = m;
    rvfi_insn = insn;
    trap_exception = exc;
    trap_cause = cause;
    intr_interrupt = intr;
    dbg_mode = dbg;
    mstatus = ms;
    mcounteren = mc;
    exp_valid = v;
    exp_vec = v ? ref_vec(m, insn, exc, cause, intr, dbg, ms, mc) : '0;
    if (v) begin
      first_s = 1'b0;
      trap_s = exc;
      mret_s = !is_revoked(exc, cause) && (insn == MRET_INSN) && (m == 2'd3) && !dbg;
      mret_mpp_s = ms[12:11];
    end
    @(negedge clk_i);
  endtask

  // Plain retirement, no interrupt, no debug, CY granted
  task automatic op(input logic [1:0] m, input logic [31:0] insn, input logic exc,
      input logic [5:0] cause, input logic [31:0] ms);
    retire(1'b1, m, insn, exc, cause, 1'b0, 1'b0, ms, 32'h1);
  endtask

  // Same user-mode word once with an illegal trap and once without
  task automatic illegal_pair(input logic [31:0] insn, input logic [31:0] ms,
      input logic [31:0] mc);
    retire(1'b1, U, insn, 1'b1, EXC_ILLEGAL_INSN, 1'b0, 1'b0, ms, mc);
    retire(1'b1, U, insn, 1'b0, 6'd0, 1'b0, 1'b0, ms, mc);
  endtask

  task automatic random_retire();
    logic [1:0]  m;
    logic [31:0] insn, ms;
    logic [5:0]  cause;
    logic [11:0] addr;
    // Mostly U or M, now and then S or reserved
    m = (rand_bits(2) == 32'd0) ? 2'(rand_bits(2)) : ((rand_bits(1) != 32'd0) ? M : U);
    case (3'(rand_bits(3)))
      3'd0: insn = MRET_INSN;
      3'd1: insn = WFI_INSN;
      3'd2: insn = URET_INSN;
      3'd3: insn = ECALL_INSN;
      3'd4: insn = (rand_bits(1) != 32'd0) ? CUSTOM1_INSN : CUSTOM0_INSN;
      3'd5, 3'd6: begin
        addr = (rand_bits(1) != 32'd0) ? CSR_CYCLE_ADDR : 12'(rand_bits(12));
        insn = {addr, 5'(rand_bits(5)), 3'(rand_bits(3)), 5'(rand_bits(5)), SYSTEM_OPCODE};
      end
      default: insn = rand_bits(32);
    endcase
    case (2'(rand_bits(2)))
      2'd0: cause = EXC_INSTR_FAULT;
      2'd1: cause = EXC_ILLEGAL_INSN;
      2'd2: cause = EXC_ECALL_UMODE;
      default: cause = EXC_INSTR_BUS_FAULT;
    endcase
    // Legal mstatus with rare bad MPP or extension bits
    ms = rand_bits(32) & ~32'h8001_F900;
    ms[12:11] = (rand_bits(1) != 32'd0) ? M : U;
    if (rand_bits(3) == 32'd0) ms[12:11] = 2'(rand_bits(2));
    if (rand_bits(3) == 32'd0) ms = ms | (rand_bits(32) & 32'h8001_E100);
    retire(rand_bits(3) != 32'd0, m, insn, rand_bits(2) == 32'd0, cause,
           rand_bits(3) == 32'd0, rand_bits(4) == 32'd0, ms, rand_bits(32));
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    rvfi_valid = 1'b0;
    exp_valid = 1'b0;
    first_s = 1'b1;
    trap_s = 1'b0;
    mret_s = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // Idle until the output register empties, then let the log settle
  task automatic drain();
    int n;
    n = 0;
    retire(1'b0, U, NOP, 1'b0, 6'd0, 1'b0, 1'b0, 32'd0, 32'd0);
    while (viol_valid && (n < 10)) begin
      @(negedge clk_i);
      n++;
    end
    if (viol_valid) begin
      timeouts++;
      $display("Timeout: viol_valid did not fall after the last retirement");
    end
    repeat (2) @(negedge clk_i);
  endtask

  task automatic begin_test(input string name);
    u_mon.test_name = name;
  endtask

  initial begin
    rst_ni = 1'b0;
    rvfi_valid = 1'b0;
    rvfi_mode = U;
    rvfi_insn = NOP;
    trap_exception = 1'b0;
    trap_cause = 6'd0;
    intr_interrupt = 1'b0;
    dbg_mode = 1'b0;
    mstatus = 32'd0;
    mcounteren = 32'd0;
    exp_vec = '0;
    begin_test("first_user");
    apply_reset();
    op(U, NOP, 1'b0, 6'd0, 32'd0);
    drain();
    begin_test("first_machine");
    apply_reset();
    op(M, NOP, 1'b0, 6'd0, MS_M);
    begin_test("illegal_insn");
    illegal_pair(URET_INSN, 32'd0, 32'h1);
    illegal_pair(CUSTOM0_INSN, 32'd0, 32'h1);
    illegal_pair(MRET_INSN, 32'd0, 32'h1);
    illegal_pair(WFI_INSN, 32'h0020_0000, 32'h1);
    illegal_pair(RD_MSTAT, 32'd0, 32'h1);
    illegal_pair(RD_CYCLE, 32'd0, 32'h0);
    illegal_pair(WFI_INSN, 32'd0, 32'h1);
    begin_test("trap_and_mret");
    op(M, NOP, 1'b1, EXC_ILLEGAL_INSN, MS_M);
    op(U, NOP, 1'b0, 6'd0, 32'd0);
    op(M, MRET_INSN, 1'b0, 6'd0, 32'd0);
    op(M, NOP, 1'b0, 6'd0, MS_M);
    op(M, MRET_INSN, 1'b0, 6'd0, 32'd0);
    retire(1'b1, M, NOP, 1'b0, 6'd0, 1'b1, 1'b0, MS_M, 32'h1);
    op(M, MRET_INSN, 1'b0, 6'd0, 32'd0);
    retire(1'b1, M, NOP, 1'b0, 6'd0, 1'b0, 1'b1, MS_M, 32'h1);
    begin_test("single_rules");
    op(2'd1, NOP, 1'b0, 6'd0, MS_M);
    op(2'd2, NOP, 1'b0, 6'd0, MS_M);
    op(M, NOP, 1'b0, 6'd0, 32'h0000_0800);
    op(M, NOP, 1'b0, 6'd0, MS_M | 32'h0000_0100);
    op(M, NOP, 1'b0, 6'd0, MS_M | 32'h0000_8000);
    op(M, NOP, 1'b0, 6'd0, MS_M | 32'h0000_2000);
    op(M, NOP, 1'b0, 6'd0, MS_M | 32'h8000_0000);
    op(U, ECALL_INSN, 1'b0, 6'd0, 32'd0);
    op(U, ECALL_INSN, 1'b1, EXC_ECALL_UMODE, 32'd0);
    retire(1'b1, U, NOP, 1'b0, 6'd0, 1'b0, 1'b1, 32'd0, 32'h1);
    retire(1'b1, U, NOP, 1'b0, 6'd0, 1'b1, 1'b0, 32'd0, 32'h1);
    begin_test("revoked");
    op(U, MRET_INSN, 1'b1, EXC_INSTR_FAULT, 32'd0);
    op(U, ECALL_INSN, 1'b1, EXC_INSTR_BUS_FAULT, 32'd0);
    op(U, URET_INSN, 1'b1, EXC_INSTR_FAULT, 32'd0);
    op(M, MRET_INSN, 1'b1, EXC_INSTR_FAULT, 32'd0);
    op(M, NOP, 1'b0, 6'd0, MS_M);
    drain();
    begin_test("random");
    // Fresh log, so the first random violation is the one latched
    apply_reset();
    for (int i = 0; i < 3000; i++) begin
      random_retire();
    end
    drain();
    $display("Errors: vector %0d, log %0d, timeout %0d",
             u_mon.vec_errors, u_mon.log_errors, timeouts);
    if ((u_mon.vec_errors + u_mon.log_errors + timeouts) == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/umode_pkg.sv
logic/retire_if.sv
logic/insn_decode.sv
logic/rule_check.sv
logic/violation_log.sv
logic/umode_checker_top.sv
verification/umode_checker_monitor.sv
verification/umode_checker_tb.sv

/* Makefile */
TOP = umode_checker_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
